//--- design/id_branch_unit.sv
// branch unit: resolves conditional branches and jumps and forms the redirect target
`timescale 1ns/10ps

module id_branch_unit (
  input  logic             i_ds_valid,
  input  logic             i_bren,
  input  id_pkg::br_func_t i_br_func,
  input  logic             i_jal,
  input  logic             i_jalr,
  input  id_pkg::xlen_t    i_rs1_data,
  input  id_pkg::xlen_t    i_rs2_data,
  input  id_pkg::pc_t      i_pc,
  input  id_pkg::xlen_t    i_imm,
  output logic             o_br_taken,
  output id_pkg::pc_t      o_br_target
);

  logic        cond;
  id_pkg::pc_t jalr_sum;

  always_comb begin
    case (i_br_func)
      id_pkg::BR_BEQ:  cond = (i_rs1_data == i_rs2_data);
      id_pkg::BR_BNE:  cond = (i_rs1_data != i_rs2_data);
      id_pkg::BR_BLT:  cond = ($signed(i_rs1_data) <  $signed(i_rs2_data));
      id_pkg::BR_BGE:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      id_pkg::BR_BLTU: cond = (i_rs1_data <  i_rs2_data);
      id_pkg::BR_BGEU: cond = (i_rs1_data >= i_rs2_data);
      default:         cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  assign o_br_taken  = i_ds_valid && (i_jal || i_jalr || (i_bren && cond));
  assign o_br_target = i_jalr ? {jalr_sum[63:1], 1'b0} // lsb cleared per isa
                              : i_pc + i_imm;

endmodule

//--- design/id_bypass.sv
// operand bypass: newest matching result from execute, memory or write-back
`timescale 1ns/10ps

module id_bypass (
  input  id_pkg::reg_addr_t i_rs1,
  input  id_pkg::reg_addr_t i_rs2,
  input  id_pkg::xlen_t     i_rf_rdata1,
  input  id_pkg::xlen_t     i_rf_rdata2,
  input  id_pkg::reg_addr_t i_es_rd,
  input  id_pkg::xlen_t     i_es_result,
  input  id_pkg::reg_addr_t i_ms_rd,
  input  id_pkg::xlen_t     i_ms_result,
  input  id_pkg::reg_addr_t i_ws_rd,
  input  id_pkg::xlen_t     i_ws_result,
  output id_pkg::xlen_t     o_rs1_data,
  output id_pkg::xlen_t     o_rs2_data
);

  // execute is youngest, so it is checked first
  function automatic id_pkg::xlen_t pick(input id_pkg::reg_addr_t rs,
                                         input id_pkg::xlen_t     rf_data);
    if (i_es_rd != '0 && rs == i_es_rd) begin
      return i_es_result;
    end else if (i_ms_rd != '0 && rs == i_ms_rd) begin
      return i_ms_result;
    end else if (i_ws_rd != '0 && rs == i_ws_rd) begin
      return i_ws_result;
    end
    return rf_data;
  endfunction

  assign o_rs1_data = pick(i_rs1, i_rf_rdata1);
  assign o_rs2_data = pick(i_rs2, i_rf_rdata2);

endmodule

//--- design/id_decoder.sv
// instruction decoder: register fields, immediates and control for the base-integer subset
`timescale 1ns/10ps

module id_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::reg_addr_t o_rs1,
  output id_pkg::reg_addr_t o_rs2,
  output id_pkg::reg_addr_t o_rd,
  output id_pkg::xlen_t     o_imm,
  output logic              o_bren,
  output id_pkg::br_func_t  o_br_func,
  output logic              o_jal,
  output logic              o_jalr,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output id_pkg::mem_op_t   o_mem_op,
  output logic              o_load_sel,
  output id_pkg::alu_op_t   o_alu_op,
  output logic              o_alu_src1_pc,
  output id_pkg::alu_src2_t o_alu_src2,
  output logic              o_invalid_inst
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  id_pkg::xlen_t imm_i;
  id_pkg::xlen_t imm_s;
  id_pkg::xlen_t imm_b;
  id_pkg::xlen_t imm_u;
  id_pkg::xlen_t imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rs1     = i_inst[19:15];
  assign o_rs2     = i_inst[24:20];
  assign o_rd      = i_inst[11:7];
  assign o_br_func = funct3;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_imm          = '0;
    o_bren         = 1'b0;
    o_jal          = 1'b0;
    o_jalr         = 1'b0;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_mem_op       = '0;
    o_load_sel     = 1'b0;
    o_alu_op       = id_pkg::alu_add;
    o_alu_src1_pc  = 1'b0;
    o_alu_src2     = id_pkg::src2_rs2;
    o_invalid_inst = 1'b0;
    case (opcode)
      id_pkg::OPC_OP_IMM: begin // addi only
        if (funct3 == 3'b000) begin
          o_gpr_wen  = 1'b1;
          o_alu_src2 = id_pkg::src2_imm;
          o_imm      = imm_i;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      id_pkg::OPC_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          o_gpr_wen = 1'b1;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          o_gpr_wen = 1'b1;
          o_alu_op  = id_pkg::alu_sub;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      id_pkg::OPC_LUI: begin
        o_gpr_wen  = 1'b1;
        o_alu_op   = id_pkg::alu_copy_b;
        o_alu_src2 = id_pkg::src2_imm;
        o_imm      = imm_u;
      end
      id_pkg::OPC_AUIPC: begin
        o_gpr_wen     = 1'b1;
        o_alu_src1_pc = 1'b1;
        o_alu_src2    = id_pkg::src2_imm;
        o_imm         = imm_u;
      end
      id_pkg::OPC_JAL: begin // rd gets pc + 4
        o_jal         = 1'b1;
        o_gpr_wen     = 1'b1;
        o_alu_src1_pc = 1'b1;
        o_alu_src2    = id_pkg::src2_four;
        o_imm         = imm_j;
      end
      id_pkg::OPC_JALR: begin
        if (funct3 == 3'b000) begin
          o_jalr        = 1'b1;
          o_gpr_wen     = 1'b1;
          o_alu_src1_pc = 1'b1;
          o_alu_src2    = id_pkg::src2_four;
          o_imm         = imm_i;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      id_pkg::OPC_BRANCH: begin
        if (funct3 inside {id_pkg::BR_BEQ, id_pkg::BR_BNE, id_pkg::BR_BLT,
                           id_pkg::BR_BGE, id_pkg::BR_BLTU, id_pkg::BR_BGEU}) begin
          o_bren = 1'b1;
          o_imm  = imm_b;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      id_pkg::OPC_LOAD: begin
        if (funct3 != 3'b111) begin // lb..ld, lbu, lhu, lwu
          o_gpr_wen  = 1'b1;
          o_mem_ren  = 1'b1;
          o_load_sel = 1'b1;
          o_mem_op   = funct3;
          o_alu_src2 = id_pkg::src2_imm;
          o_imm      = imm_i;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      id_pkg::OPC_STORE: begin
        if (!funct3[2]) begin // sb, sh, sw, sd
          o_mem_wen  = 1'b1;
          o_mem_op   = funct3;
          o_alu_src2 = id_pkg::src2_imm;
          o_imm      = imm_s;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      default: o_invalid_inst = 1'b1;
    endcase
  end

endmodule

//--- design/id_gpr_file.sv
// general register file: 32 x 64, two combinational reads and one clocked write
`timescale 1ns/10ps

module id_gpr_file (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  id_pkg::reg_addr_t i_raddr1,
  input  id_pkg::reg_addr_t i_raddr2,
  input  logic              i_wen,
  input  id_pkg::reg_addr_t i_waddr,
  input  id_pkg::xlen_t     i_wdata,
  output id_pkg::xlen_t     o_rdata1,
  output id_pkg::xlen_t     o_rdata2
);

  id_pkg::xlen_t regs [id_pkg::NUM_REGS];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < id_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin // x0 is hardwired
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  a_rdata1_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$isunknown(i_raddr1) |-> !$isunknown(o_rdata1));

endmodule

//--- design/id_pkg.sv
// decode stage package: widths, field types and opcode constants of the rv64 subset
package id_pkg;

  localparam int XLEN     = 64;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [XLEN-1:0] pc_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [2:0]      mem_op_t;   // funct3 of the load/store
  typedef logic [2:0]      br_func_t;  // funct3 of the branch

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_copy_b
  } alu_op_t;

  typedef enum logic [1:0] {
    src2_rs2,
    src2_imm,
    src2_four  // link address for jal/jalr
  } alu_src2_t;

  // major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // branch conditions
  localparam br_func_t BR_BEQ  = 3'b000;
  localparam br_func_t BR_BNE  = 3'b001;
  localparam br_func_t BR_BLT  = 3'b100;
  localparam br_func_t BR_BGE  = 3'b101;
  localparam br_func_t BR_BLTU = 3'b110;
  localparam br_func_t BR_BGEU = 3'b111;

endpackage

//--- design/id_stage_ctrl.sv
// decode stage control with the valid flag, instruction register, allowin and hazard stalls
`timescale 1ns/10ps

module id_stage_ctrl (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_fs_valid,
  input  id_pkg::inst_t     i_fs_inst,
  input  id_pkg::pc_t       i_fs_pc,
  input  logic              i_es_allowin,
  input  logic              i_es_load_sel,
  input  id_pkg::reg_addr_t i_es_rd,
  input  id_pkg::reg_addr_t i_rs1,
  input  id_pkg::reg_addr_t i_rs2,
  input  logic              i_br_taken,
  output logic              o_ds_allowin,
  output logic              o_ds_valid,
  output logic              o_ds_to_es_valid,
  output id_pkg::inst_t     o_inst,
  output id_pkg::pc_t       o_pc,
  output logic              o_br_stall
);

  logic          ds_valid;
  logic          ds_ready_go;
  logic          load_stall;
  id_pkg::inst_t inst_r;
  id_pkg::pc_t   pc_r;

  // load in execute still owes a source operand
  assign load_stall = i_es_load_sel && ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

  assign ds_ready_go      = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign o_br_stall       = i_br_taken && load_stall; // target built from stale operands
  assign o_ds_valid       = ds_valid;
  assign o_inst           = inst_r;
  assign o_pc             = pc_r;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      inst_r <= i_fs_inst;
      pc_r   <= i_fs_pc;
    end
  end

  // redirect stall only from an instruction held in the stage
  a_stall_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_br_stall |-> ds_valid);

  // a held instruction stays put until the stage lets the next one in
  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !o_ds_allowin |=> ds_valid && $stable(inst_r) && $stable(pc_r));

endmodule

//--- design/id_stage_top.sv
// decode stage top: joins stage control, decoder, register file, bypass and branch unit
`timescale 1ns/10ps

module id_stage_top (
  input  logic              i_clk,
  input  logic              i_rst_n,
  // from fetch
  input  logic              i_fs_valid,
  input  id_pkg::inst_t     i_fs_inst,
  input  id_pkg::pc_t       i_fs_pc,
  output logic              o_ds_allowin,
  // to execute
  input  logic              i_es_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::xlen_t     o_rs1_data,
  output id_pkg::xlen_t     o_rs2_data,
  output id_pkg::xlen_t     o_imm,
  output id_pkg::pc_t       o_pc,
  output id_pkg::reg_addr_t o_rd,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output id_pkg::mem_op_t   o_mem_op,
  output logic              o_load_sel,
  output id_pkg::alu_op_t   o_alu_op,
  output logic              o_alu_src1_pc,
  output id_pkg::alu_src2_t o_alu_src2,
  output logic              o_invalid_inst,
  // write back port
  input  logic              i_rf_wen,
  input  id_pkg::reg_addr_t i_rf_waddr,
  input  id_pkg::xlen_t     i_rf_wdata,
  // bypass and load-use
  input  logic              i_es_load_sel,
  input  id_pkg::reg_addr_t i_es_rd,
  input  id_pkg::xlen_t     i_es_result,
  input  id_pkg::reg_addr_t i_ms_rd,
  input  id_pkg::xlen_t     i_ms_result,
  input  id_pkg::reg_addr_t i_ws_rd,
  input  id_pkg::xlen_t     i_ws_result,
  // to fetch
  output logic              o_br_taken,
  output logic              o_br_stall,
  output id_pkg::pc_t       o_br_target
);

  logic              ds_valid;
  id_pkg::inst_t     ds_inst;
  id_pkg::reg_addr_t rs1;
  id_pkg::reg_addr_t rs2;
  id_pkg::xlen_t     rf_rdata1;
  id_pkg::xlen_t     rf_rdata2;
  logic              bren;
  id_pkg::br_func_t  br_func;
  logic              jal;
  logic              jalr;

  id_stage_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_valid       (i_fs_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_es_load_sel    (i_es_load_sel),
    .i_es_rd          (i_es_rd),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_br_taken       (o_br_taken),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_valid       (ds_valid),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_inst           (ds_inst),
    .o_pc             (o_pc),
    .o_br_stall       (o_br_stall)
  );

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_bren         (bren),
    .o_br_func      (br_func),
    .o_jal          (jal),
    .o_jalr         (jalr),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_load_sel     (o_load_sel),
    .o_alu_op       (o_alu_op),
    .o_alu_src1_pc  (o_alu_src1_pc),
    .o_alu_src2     (o_alu_src2),
    .o_invalid_inst (o_invalid_inst)
  );

  id_gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_rf_wen),
    .i_waddr  (i_rf_waddr),
    .i_wdata  (i_rf_wdata),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_bypass u_bypass (
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .i_rf_rdata1 (rf_rdata1),
    .i_rf_rdata2 (rf_rdata2),
    .i_es_rd     (i_es_rd),
    .i_es_result (i_es_result),
    .i_ms_rd     (i_ms_rd),
    .i_ms_result (i_ms_result),
    .i_ws_rd     (i_ws_rd),
    .i_ws_result (i_ws_result),
    .o_rs1_data  (o_rs1_data),
    .o_rs2_data  (o_rs2_data)
  );

  id_branch_unit u_bru (
    .i_ds_valid  (ds_valid),
    .i_bren      (bren),
    .i_br_func   (br_func),
    .i_jal       (jal),
    .i_jalr      (jalr),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_pc        (o_pc),
    .i_imm       (o_imm),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds and runs the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_id_stage -f vlog.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi

//--- tb/id_checker.sv
// result checker: compares decode stage outputs with the expected values of each test
`timescale 1ns/10ps

module id_checker (
  input  logic        i_check,
  input  logic        i_full,  // low compares the handshake outputs only
  input  int          i_test,
  input  logic [63:0] i_exp_rs1,
  input  logic [63:0] i_exp_rs2,
  input  logic [63:0] i_exp_imm,
  input  logic [63:0] i_exp_pc,
  input  logic [63:0] i_exp_target,
  input  logic [4:0]  i_exp_rd,
  input  logic [12:0] i_exp_ctrl,
  input  logic        i_exp_valid,
  input  logic        i_exp_allowin,
  input  logic        i_exp_taken,
  input  logic        i_exp_stall,
  input  logic        i_valid,
  input  logic        i_allowin,
  input  logic        i_taken,
  input  logic        i_stall,
  input  logic [63:0] i_rs1,
  input  logic [63:0] i_rs2,
  input  logic [63:0] i_imm,
  input  logic [63:0] i_pc,
  input  logic [63:0] i_target,
  input  logic [4:0]  i_rd,
  input  logic [12:0] i_ctrl,
  output int          o_passed,
  output int          o_failed
);

  int    passed = 0;
  int    failed = 0;
  string msg;

  assign o_passed = passed;
  assign o_failed = failed;

  always @(posedge i_check) begin
    msg = "";
    if (i_valid !== i_exp_valid) msg = {msg, " valid"};
    if (i_allowin !== i_exp_allowin) msg = {msg, " allowin"};
    if (i_taken !== i_exp_taken) msg = {msg, " br_taken"};
    if (i_stall !== i_exp_stall) msg = {msg, " br_stall"};
    if (i_full) begin
      if (i_rs1 !== i_exp_rs1) msg = {msg, " rs1_data"};
      if (i_rs2 !== i_exp_rs2) msg = {msg, " rs2_data"};
      if (i_imm !== i_exp_imm) msg = {msg, " imm"};
      if (i_pc !== i_exp_pc) msg = {msg, " pc"};
      if (i_rd !== i_exp_rd) msg = {msg, " rd"};
      if (i_ctrl !== i_exp_ctrl) msg = {msg, " ctrl"};
      if (i_target !== i_exp_target) msg = {msg, " br_target"};
    end
    if (msg == "") begin
      passed++;
      $display("PASSED test %0d", i_test);
    end else begin
      failed++;
      $display("FAILED %0t test %0d: wrong value in%s", $time, i_test, msg);
    end
  end

endmodule

//--- tb/tb_id_stage.sv
// testbench for the decode stage: clock, reset, stimulus table and drive loop
`timescale 1ns/10ps

module tb_id_stage;

  localparam int NROWS          = 24;
  localparam int ACCEPT_TIMEOUT = 50;
  localparam int RF = 0;  // operand source codes
  localparam int ES = 1;
  localparam int MS = 2;
  localparam int WS = 3;
  localparam logic [63:0] BPC = 64'h0000_0000_8000_0100;

  typedef struct {
    int          mode;  // 0 offer, 1 inputs only, 2 offer while blocked
    logic        wen;
    logic [4:0]  waddr;
    logic [31:0] offer_inst;
    logic [63:0] offer_pc;
    logic [31:0] inst;  // instruction expected in the stage
    logic [63:0] pc;
    logic [4:0]  es_rd, ms_rd, ws_rd;
    logic [63:0] es_res, ms_res, ws_res;
    logic        es_load, es_allowin;
    int          src1, src2;
    logic [63:0] imm, target;
    logic [12:0] ctrl;
    logic        valid, allowin, taken, stall;
  } row_t;

  logic i_clk, i_rst_n, i_fs_valid, i_es_allowin, i_rf_wen, i_es_load_sel;
  logic [31:0] i_fs_inst;
  logic [63:0] i_fs_pc, i_rf_wdata, i_es_result, i_ms_result, i_ws_result;
  logic [4:0]  i_rf_waddr, i_es_rd, i_ms_rd, i_ws_rd;
  logic o_ds_allowin, o_ds_to_es_valid, o_gpr_wen, o_mem_ren, o_mem_wen, o_load_sel;
  logic o_alu_src1_pc, o_invalid_inst, o_br_taken, o_br_stall;
  logic [63:0] o_rs1_data, o_rs2_data, o_imm, o_pc, o_br_target;
  logic [4:0]  o_rd;
  logic [2:0]  o_mem_op;
  logic [1:0]  o_alu_op, o_alu_src2;
  logic [12:0] act_ctrl;

  logic        chk_stb, chk_full;
  int          chk_id, n_passed, n_failed;
  logic [63:0] e_rs1, e_rs2, e_imm, e_pc, e_target;
  logic [4:0]  e_rd;
  logic [12:0] e_ctrl;
  logic        e_valid, e_allowin, e_taken, e_stall;

  row_t        tbl [NROWS];
  row_t        nr;
  int          n_rows;
  logic [63:0] model [32];  // expected register file contents
  logic [31:0] lfsr;
  logic        ok, timed_out;

  id_stage_top dut (.*);

  assign act_ctrl = {o_invalid_inst, o_gpr_wen, o_mem_ren, o_mem_wen, o_load_sel,
                     o_alu_src1_pc, o_alu_op, o_alu_src2, o_mem_op};

  id_checker u_chk (
    .i_check (chk_stb), .i_full (chk_full), .i_test (chk_id),
    .i_exp_rs1 (e_rs1), .i_exp_rs2 (e_rs2), .i_exp_imm (e_imm), .i_exp_pc (e_pc),
    .i_exp_target (e_target), .i_exp_rd (e_rd), .i_exp_ctrl (e_ctrl),
    .i_exp_valid (e_valid), .i_exp_allowin (e_allowin), .i_exp_taken (e_taken),
    .i_exp_stall (e_stall), .i_valid (o_ds_to_es_valid), .i_allowin (o_ds_allowin),
    .i_taken (o_br_taken), .i_stall (o_br_stall), .i_rs1 (o_rs1_data), .i_rs2 (o_rs2_data),
    .i_imm (o_imm), .i_pc (o_pc), .i_target (o_br_target), .i_rd (o_rd), .i_ctrl (act_ctrl),
    .o_passed (n_passed), .o_failed (n_failed)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // galois lfsr, one step per bit
  function automatic logic [63:0] rand64();
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [12:0] ctl(input logic inv, gw, mr, mw, ls, s1pc,
                                      input logic [1:0] aop, s2, input logic [2:0] mop);
    return {inv, gw, mr, mw, ls, s1pc, aop, s2, mop};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], id_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1, rd);
    return {f7, rs2, rs1, 3'b000, rd, id_pkg::OPC_OP};
  endfunction

  task automatic clr();
    nr = '{mode: 0, wen: 1'b0, waddr: '0, offer_inst: '0, offer_pc: '0, inst: '0, pc: '0,
           es_rd: '0, ms_rd: '0, ws_rd: '0, es_res: 64'h0bad, ms_res: 64'h0bee,
           ws_res: 64'h0cab, es_load: 1'b0, es_allowin: 1'b1, src1: RF, src2: RF,
           imm: '0, target: '0, ctrl: '0, valid: 1'b0, allowin: 1'b0, taken: 1'b0,
           stall: 1'b0};
  endtask

  task automatic fwd(input logic [4:0] erd, input logic [63:0] eres, input logic [4:0] mrd,
                     input logic [63:0] mres, input logic [4:0] wrd, input logic [63:0] wres);
    nr.es_rd = erd;
    nr.es_res = eres;
    nr.ms_rd = mrd;
    nr.ms_res = mres;
    nr.ws_rd = wrd;
    nr.ws_res = wres;
  endtask

  task automatic push(input logic [31:0] inst, input logic [63:0] pc, imm,
                      input logic [12:0] ctrl, input logic [63:0] target,
                      input logic taken, valid, allowin, stall);
    nr.inst = inst;
    nr.pc = pc;
    nr.imm = imm;
    nr.ctrl = ctrl;
    nr.target = target;
    nr.taken = taken;
    nr.valid = valid;
    nr.allowin = allowin;
    nr.stall = stall;
    if (nr.mode != 2) begin
      nr.offer_inst = inst;
      nr.offer_pc = pc;
    end
    tbl[n_rows] = nr;
    n_rows++;
    clr();
  endtask

  task automatic build_table();
    logic [12:0] c_add, c_sub, c_br, c_jmp, c_addi, c_lui, c_auipc, c_ld, c_sd, c_inv;
    logic [31:0] i_addi;
    c_add   = ctl(0, 1, 0, 0, 0, 0, id_pkg::alu_add, id_pkg::src2_rs2, 3'd0);
    c_sub   = ctl(0, 1, 0, 0, 0, 0, id_pkg::alu_sub, id_pkg::src2_rs2, 3'd0);
    c_br    = ctl(0, 0, 0, 0, 0, 0, id_pkg::alu_add, id_pkg::src2_rs2, 3'd0);
    c_jmp   = ctl(0, 1, 0, 0, 0, 1, id_pkg::alu_add, id_pkg::src2_four, 3'd0);
    c_addi  = ctl(0, 1, 0, 0, 0, 0, id_pkg::alu_add, id_pkg::src2_imm, 3'd0);
    c_lui   = ctl(0, 1, 0, 0, 0, 0, id_pkg::alu_copy_b, id_pkg::src2_imm, 3'd0);
    c_auipc = ctl(0, 1, 0, 0, 0, 1, id_pkg::alu_add, id_pkg::src2_imm, 3'd0);
    c_ld    = ctl(0, 1, 1, 0, 1, 0, id_pkg::alu_add, id_pkg::src2_imm, 3'd3);
    c_sd    = ctl(0, 0, 0, 1, 0, 0, id_pkg::alu_add, id_pkg::src2_imm, 3'd3);
    c_inv   = ctl(1, 0, 0, 0, 0, 0, id_pkg::alu_add, id_pkg::src2_rs2, 3'd0);
    i_addi  = {12'd5, 5'd0, 3'b000, 5'd10, id_pkg::OPC_OP_IMM};
    n_rows = 0;
    clr();
    nr.wen = 1'b1;  // write x5, read it back
    nr.waddr = 5'd5;
    push(enc_r(7'h00, 5'd5, 5'd5, 5'd6), 64'h8000_0000, '0, c_add, 64'h8000_0000, 0, 1, 1, 0);
    nr.wen = 1'b1;  // x0 stays zero
    nr.waddr = 5'd0;
    push(enc_r(7'h20, 5'd5, 5'd0, 5'd7), 64'h8000_0004, '0, c_sub, 64'h8000_0004, 0, 1, 1, 0);
    fwd(5'd9, 64'h1111_1111_1111_1111, 5'd9, 64'h2222, 5'd9, 64'h3333);
    nr.src1 = ES;
    push(enc_r(7'h00, 5'd10, 5'd9, 5'd8), 64'h8000_0008, '0, c_add, 64'h8000_0008, 0, 1, 1, 0);
    fwd(5'd0, 64'h4444, 5'd9, 64'h5555_0000_0000_5555, 5'd9, 64'h6666);
    nr.src1 = MS;
    push(enc_r(7'h00, 5'd5, 5'd9, 5'd8), 64'h8000_000c, '0, c_add, 64'h8000_000c, 0, 1, 1, 0);
    fwd(5'd0, 64'h7777, 5'd0, 64'h8888, 5'd0, 64'h9999);
    push(enc_r(7'h00, 5'd0, 5'd0, 5'd8), 64'h8000_0010, '0, c_add, 64'h8000_0010, 0, 1, 1, 0);
    // x1 = -5, x2 = 3 through forwarding
    for (int b = 0; b < 6; b++) begin
      logic [2:0] f3s [6];
      logic       tk [6];
      f3s = '{id_pkg::BR_BEQ, id_pkg::BR_BNE, id_pkg::BR_BLT,
              id_pkg::BR_BGE, id_pkg::BR_BLTU, id_pkg::BR_BGEU};
      tk = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
      fwd(5'd1, 64'hffff_ffff_ffff_fffb, 5'd2, 64'd3, 5'd0, 64'h0);
      nr.src1 = ES;
      nr.src2 = MS;
      if (b % 2 == 0) begin
        push(enc_b(13'd16, 5'd2, 5'd1, f3s[b]), BPC, 64'd16, c_br,
             BPC + 64'd16, tk[b], 1, 1, 0);
      end else begin
        push(enc_b(13'h1ff8, 5'd2, 5'd1, f3s[b]), BPC, 64'hffff_ffff_ffff_fff8, c_br,
             64'h8000_00f8, tk[b], 1, 1, 0);
      end
    end
    push({1'b1, 10'h200, 1'b1, 8'hff, 5'd1, id_pkg::OPC_JAL}, 64'h8000_1000,
         64'hffff_ffff_ffff_fc00, c_jmp, 64'h8000_0c00, 1, 1, 1, 0);
    fwd(5'd3, 64'h1000_0000, 5'd0, 64'h0, 5'd0, 64'h0);
    nr.src1 = ES;
    push({12'd7, 5'd3, 3'b000, 5'd1, id_pkg::OPC_JALR}, 64'h8000_2000, 64'd7, c_jmp,
         64'h1000_0006, 1, 1, 1, 0);
    push({12'hfff, 5'd3, 3'b000, 5'd4, id_pkg::OPC_OP_IMM}, 64'h8000_5000,
         64'hffff_ffff_ffff_ffff, c_addi, 64'h8000_4fff, 0, 1, 1, 0);
    push({20'h80000, 5'd4, id_pkg::OPC_LUI}, 64'h8000_4000, 64'hffff_ffff_8000_0000, c_lui,
         64'h4000, 0, 1, 1, 0);
    push({20'h12345, 5'd4, id_pkg::OPC_AUIPC}, 64'h8000_3000, 64'h1234_5000, c_auipc,
         64'h9234_8000, 0, 1, 1, 0);
    push({12'hff0, 5'd2, 3'b011, 5'd4, id_pkg::OPC_LOAD}, 64'h8000_6000,
         64'hffff_ffff_ffff_fff0, c_ld, 64'h8000_5ff0, 0, 1, 1, 0);
    push({7'd1, 5'd5, 5'd2, 3'b011, 5'd8, id_pkg::OPC_STORE}, 64'h8000_7000, 64'd40, c_sd,
         64'h8000_7028, 0, 1, 1, 0);
    push(32'hffff_ffff, 64'h8000_8000, '0, c_inv, 64'h8000_8000, 0, 1, 1, 0);
    // load in execute targets x1 of a taken beq
    fwd(5'd1, 64'h42, 5'd0, 64'h0, 5'd0, 64'h0);
    nr.es_load = 1'b1;
    nr.src1 = ES;
    nr.src2 = ES;
    push(enc_b(13'd32, 5'd1, 5'd1, id_pkg::BR_BEQ), 64'h8000_b000, 64'd32, c_br,
         64'h8000_b020, 1, 0, 0, 1);
    fwd(5'd1, 64'h42, 5'd0, 64'h0, 5'd0, 64'h0);
    nr.mode = 1;
    nr.src1 = ES;
    nr.src2 = ES;
    push(enc_b(13'd32, 5'd1, 5'd1, id_pkg::BR_BEQ), 64'h8000_b000, 64'd32, c_br,
         64'h8000_b020, 1, 1, 1, 0);
    nr.es_allowin = 1'b0;
    push(i_addi, 64'h8000_9000, 64'd5, c_addi, 64'h8000_9005, 0, 1, 0, 0);
    nr.es_allowin = 1'b0;
    nr.mode = 2;
    nr.offer_inst = {20'h80000, 5'd4, id_pkg::OPC_LUI};
    nr.offer_pc = 64'h8000_a000;
    push(i_addi, 64'h8000_9000, 64'd5, c_addi, 64'h8000_9005, 0, 1, 0, 0);
    push({20'h80000, 5'd4, id_pkg::OPC_LUI}, 64'h8000_a000, 64'hffff_ffff_8000_0000, c_lui,
         64'ha000, 0, 1, 1, 0);
  endtask

  task automatic apply(input row_t r);
    i_es_rd = r.es_rd;
    i_es_result = r.es_res;
    i_ms_rd = r.ms_rd;
    i_ms_result = r.ms_res;
    i_ws_rd = r.ws_rd;
    i_ws_result = r.ws_res;
    i_es_load_sel = r.es_load;
    i_es_allowin = r.es_allowin;
  endtask

  function automatic logic [63:0] operand(input row_t r, input int src, input logic [4:0] idx);
    case (src)
      ES:      return r.es_res;
      MS:      return r.ms_res;
      WS:      return r.ws_res;
      default: return model[idx];
    endcase
  endfunction

  task automatic request_check(input int id, input logic full);
    chk_id = id;
    chk_full = full;
    #1 chk_stb = 1'b1;
    #1 chk_stb = 1'b0;
  endtask

  task automatic offer(input logic [31:0] inst, input logic [63:0] pc, output logic acc);
    int n;
    n = 0;
    acc = 1'b0;
    i_fs_valid = 1'b1;
    i_fs_inst = inst;
    i_fs_pc = pc;
    while (!acc && n < ACCEPT_TIMEOUT) begin
      #1 acc = o_ds_allowin;
      @(posedge i_clk);
      n++;
      if (!acc) @(negedge i_clk);
    end
    @(negedge i_clk);
    i_fs_valid = 1'b0;
    i_rf_wen = 1'b0;
  endtask

  task automatic run_row(input int id, output logic acc);
    row_t r;
    r = tbl[id - 1];
    acc = 1'b1;
    @(negedge i_clk);
    if (r.mode == 0) begin
      i_es_load_sel = 1'b0;  // offer phase is free of hazards
      i_es_allowin = 1'b1;
      if (r.wen) begin
        i_rf_wen = 1'b1;
        i_rf_waddr = r.waddr;
        i_rf_wdata = rand64();
        if (r.waddr != 5'd0) model[r.waddr] = i_rf_wdata;
      end
      offer(r.offer_inst, r.offer_pc, acc);
    end
    apply(r);
    if (r.mode == 2) begin
      i_fs_valid = 1'b1;
      i_fs_inst = r.offer_inst;
      i_fs_pc = r.offer_pc;
      repeat (3) @(negedge i_clk);
    end
    e_rs1 = operand(r, r.src1, r.inst[19:15]);
    e_rs2 = operand(r, r.src2, r.inst[24:20]);
    e_imm = r.imm;
    e_pc = r.pc;
    e_target = r.target;
    e_rd = r.inst[11:7];
    e_ctrl = r.ctrl;
    e_valid = r.valid;
    e_allowin = r.allowin;
    e_taken = r.taken;
    e_stall = r.stall;
    if (acc) request_check(id, 1'b1);
    i_fs_valid = 1'b0;
  endtask

  initial begin
    lfsr = 32'h2638_dda2;
    i_rst_n = 1'b0;
    i_fs_valid = 1'b0;
    i_fs_inst = '0;
    i_fs_pc = '0;
    i_rf_wen = 1'b0;
    i_rf_waddr = '0;
    i_rf_wdata = '0;
    chk_stb = 1'b0;
    chk_full = 1'b0;
    chk_id = 0;
    timed_out = 1'b0;
    for (int i = 0; i < 32; i++) model[i] = '0;
    clr();
    apply(nr);
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    e_valid = 1'b0;  // reset check covers the handshake only
    e_allowin = 1'b1;
    e_taken = 1'b0;
    e_stall = 1'b0;
    request_check(0, 1'b0);
    build_table();
    for (int t = 1; t <= n_rows; t++) begin
      run_row(t, ok);
      if (!ok) begin
        $display("timeout: the stage never accepted the instruction of test %0d", t);
        timed_out = 1'b1;
        break;
      end
    end
    @(negedge i_clk);
    $display("tests: %0d passed, %0d failed", n_passed, n_failed);
    if (!timed_out && n_failed == 0 && n_passed == n_rows + 1) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
design/id_pkg.sv
design/id_gpr_file.sv
design/id_decoder.sv
design/id_bypass.sv
design/id_branch_unit.sv
design/id_stage_ctrl.sv
design/id_stage_top.sv
tb/id_checker.sv
tb/tb_id_stage.sv
